//--- Bender.yml
package:
  name: fft_stream

sources:
  - verilog/fft_pkg.sv
  - verilog/size_ctrl.sv
  - verilog/fft_input_buf.sv
  - verilog/fft_stage.sv
  - verilog/result_reader.sv
  - verilog/fft_stream.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_fft_stream.sv

//--- fft_stream.f
+incdir+verif
verilog/fft_pkg.sv
verilog/size_ctrl.sv
verilog/fft_input_buf.sv
verilog/fft_stage.sv
verilog/result_reader.sv
verilog/fft_stream.sv
verif/tb_fft_stream.sv

//--- verif/fft_model.svh
// reference fft model: bit reversal, fixed-point radix-2 dit stages, expected queues

// keep the low w bits of x as a signed value
function automatic longint wrap(input longint x, input int w);
	return (x << (64 - w)) >>> (64 - w);
endfunction

function automatic int rev_bits(input int idx, input int p);
	int r;
	r = 0;
	for (int i = 0; i < p; i++)
		r = (r << 1) | ((idx >> i) & 1);
	return r;
endfunction

// spectrum of in_re/in_im at length 2**p, appended to the expected queues
task automatic model_frame(input int p);
	longint xr [N_POINTS];
	longint xi [N_POINTS];
	longint tr, ti, ar, ai, wr, wi;
	int n, h, w, a, b;
	n = 1 << p;
	for (int i = 0; i < n; i++)
	begin
		xr[rev_bits(i, p)] = in_re[i];
		xi[rev_bits(i, p)] = in_im[i];
	end
	for (int s = 1; s <= p; s++)
	begin
		h = 1 << (s - 1);
		w = DATA_WIDTH + s; // one bit of growth per stage
		for (int g = 0; g < n; g += 2 * h)
			for (int j = 0; j < h; j++)
			begin
				a = g + j;
				b = a + h;
				wr = tw_re[j << (MAX_POW - s)];
				wi = tw_im[j << (MAX_POW - s)];
				tr = wrap((xr[b] * wr - xi[b] * wi + (longint'(1) << (TW_FRAC - 1))) >>> TW_FRAC, w);
				ti = wrap((xr[b] * wi + xi[b] * wr + (longint'(1) << (TW_FRAC - 1))) >>> TW_FRAC, w);
				ar = xr[a];
				ai = xi[a];
				xr[a] = wrap(ar + tr, w);
				xi[a] = wrap(ai + ti, w);
				xr[b] = wrap(ar - tr, w);
				xi[b] = wrap(ai - ti, w);
			end
	end
	exp_len.push_back(n);
	for (int i = 0; i < n; i++)
	begin
		exp_re.push_back(int'(xr[i])); // stages above p only widen
		exp_im.push_back(int'(xi[i]));
	end
endtask

//--- verif/tb_fft_stream.sv
// fft_stream testbench with clock, reset, frame generator, output collector and checks
`timescale 1ns/1ps
`default_nettype none

module tb_fft_stream;
	import fft_pkg::*;

	logic clk, aclr;
	logic sink_sop, sink_eop, sink_valid;
	logic signed [DATA_WIDTH-1:0] sink_re, sink_im;
	logic [POW_WIDTH-1:0] pow;
	logic pow_ready;
	logic source_sop, source_eop, source_valid;
	logic signed [RES_WIDTH-1:0] source_re, source_im;
	logic error;

	int in_re [N_POINTS];
	int in_im [N_POINTS];
	int exp_re [$];
	int exp_im [$];
	int exp_len [$]; // frames sent and not yet started at the output
	int out_idx;
	int out_len;
	int errors;
	int max_pending;
	bit collect_on;

	`include "fft_model.svh"

	fft_stream dut (
		.clk, .aclr, .sink_sop, .sink_eop, .sink_valid, .sink_re, .sink_im,
		.pow, .pow_ready, .source_sop, .source_eop, .source_valid,
		.source_re, .source_im, .error
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	task automatic expect_value(input bit ok, input string what);
		assert (ok)
		else
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s", $time, what);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic timeout_fail(input string what);
		errors++;
		$display("timed out waiting for %s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		aclr = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		aclr = 1'b0;
		@(negedge clk);
		expect_value(!source_valid && !error && pow_ready, "outputs after reset");
	endtask

	// count samples with sop on the first and eop on the last
	task automatic drive_frame(input int p, input int count);
		for (int i = 0; i < count; i++)
		begin
			@(posedge clk);
			#1;
			pow = POW_WIDTH'(p);
			sink_valid = 1'b1;
			sink_sop = i == 0;
			sink_eop = i == count - 1;
			sink_re = DATA_WIDTH'(in_re[i]);
			sink_im = DATA_WIDTH'(in_im[i]);
		end
		@(posedge clk);
		#1;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
	endtask

	task automatic send_checked(input int p);
		model_frame(p);
		drive_frame(p, 1 << p);
		if (exp_len.size() > max_pending)
			max_pending = exp_len.size();
	endtask

	task automatic fill_frame(input int kind); // 0 random, 1 impulse, 2 constant
		for (int i = 0; i < N_POINTS; i++)
		begin
			in_re[i] = kind == 0 ? int'($urandom % 16384) - 8192
				: kind == 1 ? (i == 0) * 10000 : 1000;
			in_im[i] = kind == 0 ? int'($urandom % 16384) - 8192 : kind == 1 ? 0 : -500;
		end
	endtask

	// frame held by the input buffer and then taken by stage 1
	task automatic wait_inbuf_free();
		int n;
		int m;
		n = 0;
		m = 0;
		while (!dut.ready[0] && n < 20000)
		begin
			@(negedge clk);
			n++;
		end
		if (n >= 20000)
			timeout_fail("the input buffer to fill");
		while (dut.ready[0] && m < 20000)
		begin
			@(negedge clk);
			m++;
		end
		if (m >= 20000)
			timeout_fail("the input buffer to release its frame");
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while ((exp_len.size() != 0 || out_idx != 0 || !pow_ready) && n < 20000)
		begin
			@(negedge clk);
			n++;
		end
		if (n >= 20000)
			timeout_fail("all frames to leave the pipeline");
	endtask

	task automatic wait_error();
		int n;
		n = 0;
		while (!error && n < 200)
		begin
			@(negedge clk);
			n++;
		end
		if (n >= 200)
			timeout_fail("error to rise after bad framing");
	endtask

	// outputs settle after the rising edge and get sampled on the falling one
	always @(negedge clk)
		if (collect_on)
		begin
			if (source_valid)
			begin
				if (out_idx == 0)
				begin
					expect_value(exp_len.size() > 0, "output frame with none expected");
					out_len = exp_len.pop_front();
				end
				expect_value(source_sop == (out_idx == 0), "sop on the wrong word");
				expect_value(source_eop == (out_idx == out_len - 1), "eop on the wrong word");
				expect_value(int'(source_re) == exp_re[0] && int'(source_im) == exp_im[0],
					$sformatf("word %0d is %0d,%0d, model %0d,%0d", out_idx,
					source_re, source_im, exp_re[0], exp_im[0]));
				void'(exp_re.pop_front());
				void'(exp_im.pop_front());
				out_idx = out_idx == out_len - 1 ? 0 : out_idx + 1;
			end
			else
				expect_value(out_idx == 0, "valid gap inside an output frame");
		end

	initial
	begin
		int p;
		aclr = 1'b1;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		sink_valid = 1'b0;
		sink_re = '0;
		sink_im = '0;
		pow = POW_WIDTH'(MAX_POW);
		errors = 0;
		out_idx = 0;
		out_len = 0;
		max_pending = 0;
		collect_on = 1'b1;
		void'($urandom(32'h4797_c7bd));
		apply_reset();

		for (int f = 0; f < 20; f++) // full length and one frame at a time
		begin
			fill_frame(0);
			send_checked(MAX_POW);
			wait_idle();
		end

		for (int q = MIN_POW; q <= MAX_POW; q++)
		begin
			fill_frame(1);
			send_checked(q);
			wait_inbuf_free();
			fill_frame(2);
			send_checked(q);
			wait_idle(); // empty pipeline before the next length
		end

		for (int f = 0; f < 6; f++)
		begin
			p = MIN_POW + int'($urandom % (MAX_POW - MIN_POW + 1));
			wait_idle();
			for (int r = 0; r < 2; r++)
			begin
				fill_frame(0);
				send_checked(p);
				wait_inbuf_free();
			end
		end
		wait_idle();

		max_pending = 0;
		for (int f = 0; f < 12; f++) // back to back
		begin
			fill_frame(0);
			send_checked(MAX_POW);
			wait_inbuf_free();
		end
		expect_value(max_pending >= 3, $sformatf("only %0d frames in flight", max_pending));
		wait_idle();
		expect_value(!error, "error raised by legal traffic");

		// early eop followed by a legal frame
		collect_on = 1'b0;
		fill_frame(0);
		drive_frame(MAX_POW, 10);
		wait_error();
		wait_inbuf_free();
		drive_frame(MAX_POW, N_POINTS);
		wait_idle();
		expect_value(error, "error cleared by later traffic");

		// second sop while the input buffer still holds a frame
		apply_reset();
		drive_frame(MAX_POW, N_POINTS);
		drive_frame(MAX_POW, N_POINTS);
		wait_error();
		wait_inbuf_free();
		drive_frame(MAX_POW, N_POINTS);
		wait_inbuf_free();
		expect_value(error, "overflow error cleared by later traffic");

		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/fft_input_buf.sv
// input frame buffer, bit-reversed write order, serves the first stage
`timescale 1ns/1ps
`default_nettype none

module fft_input_buf
	import fft_pkg::*;
(
	input  logic clk,
	input  logic aclr,
	input  logic sink_sop,
	input  logic sink_eop,
	input  logic sink_valid,
	input  logic signed [DATA_WIDTH-1:0] sink_re,
	input  logic signed [DATA_WIDTH-1:0] sink_im,
	input  logic [POW_WIDTH-1:0] pow_reg,
	input  logic [MAX_POW-1:0] rdaddr,
	input  logic rdack,
	output logic signed [DATA_WIDTH-1:0] q_re,
	output logic signed [DATA_WIDTH-1:0] q_im,
	output logic ready,
	output logic error
);
	logic signed [DATA_WIDTH-1:0] mem_re [N_POINTS];
	logic signed [DATA_WIDTH-1:0] mem_im [N_POINTS];
	logic [MAX_POW-1:0] wr_cnt; // next sample index
	logic [MAX_POW-1:0] wr_idx;
	logic [MAX_POW-1:0] wr_addr;
	logic full;
	logic overflow;
	logic frame_done;

	// frame held and not yet being released
	assign full = ready && !rdack;

	assign wr_idx = sink_sop ? '0 : wr_cnt;
	assign wr_addr = bit_rev(wr_idx, pow_reg); // first stage sees DIT order
	assign overflow = sink_valid && sink_sop && full;
	assign frame_done = sink_valid && sink_eop;

	// read side is combinational from the reader's address
	assign q_re = mem_re[rdaddr];
	assign q_im = mem_im[rdaddr];

	always_ff @(posedge clk)
		if (sink_valid)
		begin
			mem_re[wr_addr] <= sink_re;
			mem_im[wr_addr] <= sink_im;
		end

	always_ff @(posedge clk, posedge aclr)
		if (aclr)
		begin
			wr_cnt <= '0;
			ready <= 1'b0;
			error <= 1'b0;
		end
		else
		begin
			if (sink_valid)
				wr_cnt <= wr_idx + 1'b1;

			if (rdack)
				ready <= 1'b0; // reader has the frame, buffer is free
			else if (frame_done)
				ready <= 1'b1;
			else if (overflow)
				ready <= 1'b0; // held frame is overwritten

			if (overflow)
				error <= 1'b1;
		end

endmodule

`default_nettype wire

//--- verilog/fft_pkg.sv
// fft sizes, twiddle tables, stage control states and bit reverse helper
`default_nettype none

package fft_pkg;

	localparam int MAX_POW = 5; // up to 32 points, one stage per bit
	localparam int MIN_POW = 2;
	localparam int POW_WIDTH = 3;
	localparam int DATA_WIDTH = 16;
	localparam int RES_WIDTH = DATA_WIDTH + MAX_POW; // one bit of growth per stage
	localparam int N_POINTS = 2 ** MAX_POW;
	localparam int TW_FRAC = 14;
	localparam int TW_WIDTH = 16;
	localparam int TW_NUM = 2 ** (MAX_POW - 1);
	localparam int TW_ROUND = 2 ** (TW_FRAC - 1); // half lsb, added before the shift
	localparam real PI = 3.14159265358979;

	typedef logic signed [TW_WIDTH-1:0] tw_t;
	typedef tw_t tw_table_t [TW_NUM];

	// control of one butterfly stage
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		CALC,
		FULL,
		RELEASE
	} ctrl_state_t;

	// W^j = cos(2*pi*j/N) - i*sin(2*pi*j/N), scaled by 2**TW_FRAC
	function automatic tw_table_t make_tw(input bit imag);
		tw_table_t tab;
		real ang;
		for (int j = 0; j < TW_NUM; j++)
		begin
			ang = 2.0 * PI * j / N_POINTS;
			if (imag)
				tab[j] = tw_t'(int'(-$sin(ang) * (2.0 ** TW_FRAC)));
			else
				tab[j] = tw_t'(int'($cos(ang) * (2.0 ** TW_FRAC)));
		end
		return tab;
	endfunction

	localparam tw_table_t tw_re = make_tw(1'b0);
	localparam tw_table_t tw_im = make_tw(1'b1);

	// mirror the low pow bits of addr, upper bits end up zero
	function automatic logic [MAX_POW-1:0] bit_rev(
		input logic [MAX_POW-1:0] addr,
		input logic [POW_WIDTH-1:0] pow
	);
		logic [MAX_POW-1:0] r;
		r = '0;
		for (int i = 0; i < MAX_POW; i++)
			if (i < pow)
				r[pow - 1 - i] = addr[i];
		return r;
	endfunction

endpackage

`default_nettype wire

//--- verilog/fft_stage.sv
// one radix-2 DIT stage: own frame buffer, butterflies with twiddle multiply
`timescale 1ns/1ps
`default_nettype none

module fft_stage
	import fft_pkg::*;
#(
	parameter int STAGE = 1 // 1..MAX_POW, butterfly span 2**(STAGE-1)
)(
	input  logic clk,
	input  logic aclr,
	input  logic [POW_WIDTH-1:0] pow_reg,
	input  logic sink_ready,
	output logic [MAX_POW-1:0] sink_rdaddr,
	input  logic signed [DATA_WIDTH+STAGE-2:0] sink_re,
	input  logic signed [DATA_WIDTH+STAGE-2:0] sink_im,
	output logic sink_rdack,
	input  logic [MAX_POW-1:0] source_rdaddr,
	input  logic source_rdack,
	output logic signed [DATA_WIDTH+STAGE-1:0] source_re,
	output logic signed [DATA_WIDTH+STAGE-1:0] source_im,
	output logic source_ready
);
	ctrl_state_t state;
	logic [MAX_POW:0] step; // load: word and phase, calc: pair and phase
	logic bypass;
	logic load_wr;
	logic calc_wr;
	logic signed [DATA_WIDTH+STAGE-1:0] mem_re [N_POINTS];
	logic signed [DATA_WIDTH+STAGE-1:0] mem_im [N_POINTS];
	logic signed [DATA_WIDTH+STAGE-1:0] hold_re, hold_im; // word fetched from upstream
	logic signed [DATA_WIDTH+STAGE-1:0] t_re, t_im; // b * W of the current pair
	logic signed [DATA_WIDTH+STAGE-1:0] a_re, a_im;
	logic signed [DATA_WIDTH+STAGE-1:0] b_re, b_im;
	logic signed [DATA_WIDTH+STAGE+TW_WIDTH:0] acc_re, acc_im;
	logic [MAX_POW-1:0] pair;
	logic [MAX_POW-1:0] grp_pos; // position within the butterfly group
	logic [MAX_POW-1:0] a_addr;
	logic [MAX_POW-1:0] b_addr;
	logic [MAX_POW-2:0] tw_idx;
	tw_t w_re, w_im;

	// stages above the frame length only widen and pass data
	assign bypass = STAGE > pow_reg;
	assign load_wr = state == LOAD && step[0];
	assign calc_wr = state == CALC && step[0] && !bypass;

	assign sink_rdaddr = step[MAX_POW:1];
	assign sink_rdack = state == RELEASE;
	assign source_ready = state == FULL;
	assign source_re = mem_re[source_rdaddr];
	assign source_im = mem_im[source_rdaddr];

	always_comb
	begin
		pair = {1'b0, step[MAX_POW-1:1]};
		grp_pos = pair & MAX_POW'((1 << (STAGE - 1)) - 1);
		a_addr = ((pair >> (STAGE - 1)) << STAGE) | grp_pos;
		b_addr = a_addr | MAX_POW'(1 << (STAGE - 1));
		tw_idx = (MAX_POW-1)'(grp_pos << (MAX_POW - STAGE));

		a_re = mem_re[a_addr];
		a_im = mem_im[a_addr];
		b_re = mem_re[b_addr];
		b_im = mem_im[b_addr];
		w_re = tw_re[tw_idx];
		w_im = tw_im[tw_idx];

		// complex multiply with round to nearest
		acc_re = b_re * w_re - b_im * w_im + TW_ROUND;
		acc_im = b_re * w_im + b_im * w_re + TW_ROUND;
	end

	always_ff @(posedge clk)
	begin
		if (state == LOAD && !step[0])
		begin
			hold_re <= sink_re; // sign extended
			hold_im <= sink_im;
		end
		if (load_wr)
		begin
			mem_re[step[MAX_POW:1]] <= hold_re;
			mem_im[step[MAX_POW:1]] <= hold_im;
		end
		if (state == CALC && !step[0])
		begin
			t_re <= (DATA_WIDTH+STAGE)'(acc_re >>> TW_FRAC);
			t_im <= (DATA_WIDTH+STAGE)'(acc_im >>> TW_FRAC);
		end
		if (calc_wr)
		begin
			mem_re[a_addr] <= a_re + t_re;
			mem_im[a_addr] <= a_im + t_im;
			mem_re[b_addr] <= a_re - t_re;
			mem_im[b_addr] <= a_im - t_im;
		end
	end

	always_ff @(posedge clk, posedge aclr)
		if (aclr)
		begin
			state <= IDLE;
			step <= '0;
		end
		else
			case (state)
				IDLE:
					if (sink_ready)
					begin
						state <= LOAD;
						step <= '0;
					end
				LOAD:
					if (&step)
						state <= RELEASE; // whole frame copied
					else
						step <= step + 1'b1;
				RELEASE:
					if (!sink_ready)
					begin
						state <= CALC;
						step <= '0;
					end
				CALC:
				begin
					if (!step[MAX_POW])
						step <= step + 1'b1;
					// wait here while the reader still holds rdack of the last frame
					if (step >= N_POINTS - 1 && !source_rdack)
						state <= FULL;
				end
				FULL:
					if (source_rdack)
						state <= IDLE;
				default:
					state <= IDLE;
			endcase

endmodule

`default_nettype wire

//--- verilog/fft_stream.sv
// streaming fft top: size control, input buffer, stage chain, result reader
`timescale 1ns/1ps
`default_nettype none

module fft_stream
	import fft_pkg::*;
(
	input  logic clk,
	input  logic aclr,
	input  logic sink_sop, sink_eop, sink_valid, // valid solid from sop to eop
	input  logic signed [DATA_WIDTH-1:0] sink_re, sink_im,
	input  logic [POW_WIDTH-1:0] pow, // frame length 2**pow
	output logic pow_ready,
	output logic source_sop, source_eop, source_valid,
	output logic signed [RES_WIDTH-1:0] source_re, source_im,
	output logic error
);
	logic [POW_WIDTH-1:0] pow_reg;
	logic sop_reg, eop_reg, valid_reg;
	logic signed [DATA_WIDTH-1:0] re_reg, im_reg;
	logic [MAX_POW:0] ready; // ready[k] from buffer k
	logic [MAX_POW:0] rdack; // rdack[k] from reader k+1
	logic [MAX_POW-1:0] rdaddr [MAX_POW+1];
	logic size_err, buf_err;

	genvar k;
	for (k = 0; k <= MAX_POW; k++)
	begin : lnk
		logic signed [DATA_WIDTH+k-1:0] re, im; // read data of buffer k
	end

	size_ctrl u_size (
		.clk, .aclr, .pow, .source_eop,
		.sink_sop, .sink_eop, .sink_valid, .sink_re, .sink_im,
		.pow_reg, .pow_ready,
		.sop_reg, .eop_reg, .valid_reg, .re_reg, .im_reg,
		.error(size_err)
	);

	fft_input_buf u_inbuf (
		.clk, .aclr, .pow_reg,
		.sink_sop(sop_reg), .sink_eop(eop_reg), .sink_valid(valid_reg),
		.sink_re(re_reg), .sink_im(im_reg),
		.rdaddr(rdaddr[0]), .rdack(rdack[0]),
		.q_re(lnk[0].re), .q_im(lnk[0].im),
		.ready(ready[0]), .error(buf_err)
	);

	for (k = 1; k <= MAX_POW; k++)
	begin : stg
		fft_stage #(.STAGE(k)) u_stage (
			.clk, .aclr, .pow_reg,
			.sink_ready(ready[k-1]), .sink_rdaddr(rdaddr[k-1]), .sink_rdack(rdack[k-1]),
			.sink_re(lnk[k-1].re), .sink_im(lnk[k-1].im),
			.source_rdaddr(rdaddr[k]), .source_rdack(rdack[k]),
			.source_re(lnk[k].re), .source_im(lnk[k].im),
			.source_ready(ready[k])
		);
	end

	// always the last stage, lower lengths are carried through by bypass
	result_reader u_reader (
		.clk, .aclr, .pow_reg,
		.sink_ready(ready[MAX_POW]), .sink_rdaddr(rdaddr[MAX_POW]), .sink_rdack(rdack[MAX_POW]),
		.sink_re(lnk[MAX_POW].re), .sink_im(lnk[MAX_POW].im),
		.source_sop, .source_eop, .source_valid, .source_re, .source_im
	);

	assign error = size_err | buf_err;

endmodule

`default_nettype wire

//--- verilog/result_reader.sv
// result reader: streams the last stage buffer out with sop, eop and valid
`timescale 1ns/1ps
`default_nettype none

module result_reader
	import fft_pkg::*;
(
	input  logic clk,
	input  logic aclr,
	input  logic [POW_WIDTH-1:0] pow_reg,
	input  logic sink_ready,
	output logic [MAX_POW-1:0] sink_rdaddr,
	input  logic signed [DATA_WIDTH+MAX_POW-1:0] sink_re,
	input  logic signed [DATA_WIDTH+MAX_POW-1:0] sink_im,
	output logic sink_rdack,
	output logic source_sop,
	output logic source_eop,
	output logic source_valid,
	output logic signed [RES_WIDTH-1:0] source_re,
	output logic signed [RES_WIDTH-1:0] source_im
);
	logic [MAX_POW-1:0] cnt;
	logic [MAX_POW-1:0] last;
	logic active;

	assign last = MAX_POW'((1 << pow_reg) - 1);
	assign active = sink_ready && !sink_rdack; // frame present and not yet read
	assign sink_rdaddr = cnt;

	always_ff @(posedge clk, posedge aclr)
		if (aclr)
		begin
			cnt <= '0;
			sink_rdack <= 1'b0;
			source_valid <= 1'b0;
			source_sop <= 1'b0;
			source_eop <= 1'b0;
		end
		else
		begin
			source_valid <= active;
			source_sop <= active && cnt == '0;
			source_eop <= active && cnt == last;
			if (active)
			begin
				if (cnt == last)
				begin
					cnt <= '0;
					sink_rdack <= 1'b1;
				end
				else
					cnt <= cnt + 1'b1;
			end
			else if (!sink_ready)
				sink_rdack <= 1'b0; // buffer let go, close the handshake
		end

	always_ff @(posedge clk)
		if (active)
		begin
			source_re <= RES_WIDTH'(sink_re);
			source_im <= RES_WIDTH'(sink_im);
		end

endmodule

`default_nettype wire

//--- verilog/size_ctrl.sv
// size controller: pow latch, input stream register, framing checks, pow_ready
`timescale 1ns/1ps
`default_nettype none

module size_ctrl
	import fft_pkg::*;
(
	input  logic clk,
	input  logic aclr,
	input  logic [POW_WIDTH-1:0] pow,
	input  logic sink_sop, sink_eop, sink_valid,
	input  logic signed [DATA_WIDTH-1:0] sink_re, sink_im,
	input  logic source_eop, // one pulse per frame leaving the design
	output logic [POW_WIDTH-1:0] pow_reg,
	output logic pow_ready,
	output logic sop_reg, eop_reg, valid_reg,
	output logic signed [DATA_WIDTH-1:0] re_reg, im_reg,
	output logic error
);
	logic [POW_WIDTH:0] frames; // frames entered minus frames emitted
	logic [MAX_POW-1:0] cnt; // index of the next sample in the frame
	logic in_frame;
	logic start;
	logic [POW_WIDTH-1:0] pow_clamp;
	logic [POW_WIDTH-1:0] pow_eff;
	logic [MAX_POW-1:0] samp;
	logic [MAX_POW-1:0] samp_last;
	logic bad_pow, bad_eop, bad_valid;

	assign pow_ready = frames == '0;
	assign start = sink_sop && sink_valid;

	always_comb
	begin
		if (pow < MIN_POW)
			pow_clamp = POW_WIDTH'(MIN_POW);
		else if (pow > MAX_POW)
			pow_clamp = POW_WIDTH'(MAX_POW);
		else
			pow_clamp = pow;

		// a new length only takes effect on an empty pipeline
		pow_eff = (start && pow_ready) ? pow_clamp : pow_reg;
		samp = sink_sop ? '0 : cnt;
		samp_last = MAX_POW'((1 << pow_eff) - 1);

		bad_pow = start && (pow < MIN_POW || pow > MAX_POW || (!pow_ready && pow != pow_reg));
		bad_eop = sink_valid && sink_eop && samp != samp_last;
		bad_valid = in_frame && !sink_valid; // gap inside a frame
	end

	always_ff @(posedge clk, posedge aclr)
		if (aclr)
		begin
			frames <= '0;
			cnt <= '0;
			in_frame <= 1'b0;
			pow_reg <= POW_WIDTH'(MAX_POW);
			error <= 1'b0;
			sop_reg <= 1'b0;
			eop_reg <= 1'b0;
			valid_reg <= 1'b0;
		end
		else
		begin
			frames <= frames + (POW_WIDTH+1)'(start) - (POW_WIDTH+1)'(source_eop);
			if (sink_valid)
				cnt <= samp + 1'b1;
			if (start && !sink_eop)
				in_frame <= 1'b1;
			else if (sink_valid && sink_eop)
				in_frame <= 1'b0;
			if (start && pow_ready)
				pow_reg <= pow_clamp;
			if (bad_pow || bad_eop || bad_valid)
				error <= 1'b1; // sticky
			sop_reg <= sink_sop && sink_valid;
			eop_reg <= sink_eop && sink_valid;
			valid_reg <= sink_valid;
		end

	always_ff @(posedge clk)
	begin
		re_reg <= sink_re;
		im_reg <= sink_im;
	end

endmodule

`default_nettype wire
